// File: hdl/decode_pkg.sv
`default_nettype none

package decode_pkg;

	// One value per decoded RV64IM instruction
	typedef enum logic [6:0] {
		OP_UNKNOWN,
		OP_LB, OP_LH, OP_LW, OP_LD, OP_LBU, OP_LHU, OP_LWU,
		OP_SB, OP_SH, OP_SW, OP_SD,
		OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
		OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI,
		OP_SLLI, OP_SRLI, OP_SRAI,
		OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
		OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND,
		OP_ADDIW, OP_SLLIW, OP_SRLIW, OP_SRAIW,
		OP_ADDW, OP_SUBW, OP_SLLW, OP_SRLW, OP_SRAW,
		OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU,
		OP_DIV, OP_DIVU, OP_REM, OP_REMU,
		OP_MULW, OP_DIVW, OP_DIVUW, OP_REMW, OP_REMUW,
		OP_LUI, OP_AUIPC, OP_JAL, OP_JALR,
		OP_FENCE, OP_FENCE_I, OP_ECALL, OP_EBREAK,
		OP_RDCYCLE, OP_RDCYCLEH, OP_RDTIME, OP_RDTIMEH,
		OP_RDINSTRET, OP_RDINSTRETH
	} op_e;

	typedef enum logic [2:0] {
		FMT_R,
		FMT_I,
		FMT_S,
		FMT_SB,
		FMT_U,
		FMT_UJ,
		FMT_UNKNOWN
	} fmt_e;

	typedef struct packed {
		logic       is_load;
		logic       is_shift;     // Arithmetic right shift
		logic       is_special;
		logic       is_bracket;   // Memory operand
		logic       is_signed;
		logic [3:0] special_code;
	} decode_flags_t;

	localparam logic [3:0] SPECIAL_NONE    = 4'd0;
	localparam logic [3:0] SPECIAL_COUNTER = 4'd1;
	localparam logic [3:0] SPECIAL_JUMP    = 4'd2;

	typedef enum logic {
		ST_RUN,
		ST_HALTED
	} ctrl_state_e;

endpackage

`default_nettype wire

// File: hdl/decode_if.sv
`timescale 1ns/1ps
`default_nettype none

interface decode_if;
	import decode_pkg::*;

	op_e           op;
	fmt_e          fmt;
	decode_flags_t flags;
	logic          illegal;

	modport classifier (
		output op,
		output fmt,
		output flags,
		output illegal
	);

	modport fields (
		input op,
		input fmt,
		input flags,
		input illegal
	);

	// Counter block only needs to know which read and whether it retires
	modport counters (
		input op,
		input illegal
	);

endinterface

`default_nettype wire

// File: hdl/instr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module instr_decoder (
	input logic [31:0]   instr,
	decode_if.classifier dec
);
	import decode_pkg::*;

	localparam logic [6:0] OPC_LOAD     = 7'b0000011;
	localparam logic [6:0] OPC_MISC_MEM = 7'b0001111;
	localparam logic [6:0] OPC_OP_IMM   = 7'b0010011;
	localparam logic [6:0] OPC_AUIPC    = 7'b0010111;
	localparam logic [6:0] OPC_OP_IMM32 = 7'b0011011;
	localparam logic [6:0] OPC_STORE    = 7'b0100011;
	localparam logic [6:0] OPC_OP       = 7'b0110011;
	localparam logic [6:0] OPC_LUI      = 7'b0110111;
	localparam logic [6:0] OPC_OP32     = 7'b0111011;
	localparam logic [6:0] OPC_BRANCH   = 7'b1100011;
	localparam logic [6:0] OPC_JALR     = 7'b1100111;
	localparam logic [6:0] OPC_JAL      = 7'b1101111;
	localparam logic [6:0] OPC_SYSTEM   = 7'b1110011;

	logic [6:0]    opcode;
	logic [2:0]    funct3;
	logic [6:0]    funct7;
	op_e           op_d;
	fmt_e          fmt_d;
	decode_flags_t flags_d;

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];

	always_comb
	begin
		op_d = OP_UNKNOWN;
		case (opcode)
			OPC_LOAD:
				case (funct3)
					3'b000: op_d = OP_LB;
					3'b001: op_d = OP_LH;
					3'b010: op_d = OP_LW;
					3'b011: op_d = OP_LD;
					3'b100: op_d = OP_LBU;
					3'b101: op_d = OP_LHU;
					3'b110: op_d = OP_LWU;
					default: op_d = OP_UNKNOWN;
				endcase
			OPC_STORE:
				case (funct3)
					3'b000: op_d = OP_SB;
					3'b001: op_d = OP_SH;
					3'b010: op_d = OP_SW;
					3'b011: op_d = OP_SD;
					default: op_d = OP_UNKNOWN;
				endcase
			OPC_BRANCH:
				case (funct3)
					3'b000: op_d = OP_BEQ;
					3'b001: op_d = OP_BNE;
					3'b100: op_d = OP_BLT;
					3'b101: op_d = OP_BGE;
					3'b110: op_d = OP_BLTU;
					3'b111: op_d = OP_BGEU;
					default: op_d = OP_UNKNOWN;
				endcase
			OPC_OP_IMM: // 6-bit shamt, so funct6 only
				casez ({funct7[6:1], funct3})
					9'b??????_000: op_d = OP_ADDI;
					9'b??????_010: op_d = OP_SLTI;
					9'b??????_011: op_d = OP_SLTIU;
					9'b??????_100: op_d = OP_XORI;
					9'b??????_110: op_d = OP_ORI;
					9'b??????_111: op_d = OP_ANDI;
					9'b000000_001: op_d = OP_SLLI;
					9'b000000_101: op_d = OP_SRLI;
					9'b010000_101: op_d = OP_SRAI;
					default: op_d = OP_UNKNOWN;
				endcase
			OPC_OP_IMM32:
				casez ({funct7, funct3})
					10'b???????_000: op_d = OP_ADDIW;
					10'b0000000_001: op_d = OP_SLLIW;
					10'b0000000_101: op_d = OP_SRLIW;
					10'b0100000_101: op_d = OP_SRAIW;
					default: op_d = OP_UNKNOWN;
				endcase
			OPC_OP:
				case ({funct7, funct3})
					10'b0000000_000: op_d = OP_ADD;
					10'b0100000_000: op_d = OP_SUB;
					10'b0000000_001: op_d = OP_SLL;
					10'b0000000_010: op_d = OP_SLT;
					10'b0000000_011: op_d = OP_SLTU;
					10'b0000000_100: op_d = OP_XOR;
					10'b0000000_101: op_d = OP_SRL;
					10'b0100000_101: op_d = OP_SRA;
					10'b0000000_110: op_d = OP_OR;
					10'b0000000_111: op_d = OP_AND;
					10'b0000001_000: op_d = OP_MUL;
					10'b0000001_001: op_d = OP_MULH;
					10'b0000001_010: op_d = OP_MULHSU;
					10'b0000001_011: op_d = OP_MULHU;
					10'b0000001_100: op_d = OP_DIV;
					10'b0000001_101: op_d = OP_DIVU;
					10'b0000001_110: op_d = OP_REM;
					10'b0000001_111: op_d = OP_REMU;
					default: op_d = OP_UNKNOWN;
				endcase
			OPC_OP32:
				case ({funct7, funct3})
					10'b0000000_000: op_d = OP_ADDW;
					10'b0100000_000: op_d = OP_SUBW;
					10'b0000000_001: op_d = OP_SLLW;
					10'b0000000_101: op_d = OP_SRLW;
					10'b0100000_101: op_d = OP_SRAW;
					10'b0000001_000: op_d = OP_MULW;
					10'b0000001_100: op_d = OP_DIVW;
					10'b0000001_101: op_d = OP_DIVUW;
					10'b0000001_110: op_d = OP_REMW;
					10'b0000001_111: op_d = OP_REMUW;
					default: op_d = OP_UNKNOWN;
				endcase
			OPC_LUI: op_d = OP_LUI;
			OPC_AUIPC: op_d = OP_AUIPC;
			OPC_JAL: op_d = OP_JAL;
			OPC_JALR: op_d = (funct3 == 3'b000) ? OP_JALR : OP_UNKNOWN;
			OPC_MISC_MEM:
				case (funct3)
					3'b000: op_d = OP_FENCE;
					3'b001: op_d = OP_FENCE_I;
					default: op_d = OP_UNKNOWN;
				endcase
			OPC_SYSTEM:
				if (instr == 32'h0000_0073)
					op_d = OP_ECALL;
				else if (instr == 32'h0010_0073)
					op_d = OP_EBREAK;
				else if (funct3 == 3'b010 && instr[19:15] == 5'd0) // csrrs rd, csr, x0
					case (instr[31:20])
						12'hc00: op_d = OP_RDCYCLE;
						12'hc01: op_d = OP_RDTIME;
						12'hc02: op_d = OP_RDINSTRET;
						12'hc80: op_d = OP_RDCYCLEH;
						12'hc81: op_d = OP_RDTIMEH;
						12'hc82: op_d = OP_RDINSTRETH;
						default: op_d = OP_UNKNOWN;
					endcase
			default: op_d = OP_UNKNOWN;
		endcase
	end

	// Format and attribute flags follow from the opcode alone
	always_comb
	begin
		fmt_d = FMT_I;
		flags_d = '0;
		flags_d.is_signed = 1'b1;
		case (op_d)
			OP_SB, OP_SH, OP_SW, OP_SD: fmt_d = FMT_S;
			OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU: fmt_d = FMT_SB;
			OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU, OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND,
			OP_ADDW, OP_SUBW, OP_SLLW, OP_SRLW, OP_SRAW,
			OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU, OP_DIV, OP_DIVU, OP_REM, OP_REMU,
			OP_MULW, OP_DIVW, OP_DIVUW, OP_REMW, OP_REMUW: fmt_d = FMT_R;
			OP_LUI, OP_AUIPC: fmt_d = FMT_U;
			OP_JAL: fmt_d = FMT_UJ;
			default: fmt_d = FMT_I;
		endcase

		if (op_d inside {OP_LB, OP_LH, OP_LW, OP_LD, OP_LBU, OP_LHU, OP_LWU})
			flags_d.is_load = 1'b1;
		if (flags_d.is_load || fmt_d == FMT_S)
			flags_d.is_bracket = 1'b1;
		if (op_d inside {OP_SRAI, OP_SRA, OP_SRAIW, OP_SRAW})
			flags_d.is_shift = 1'b1;
		if (op_d inside {OP_LBU, OP_LHU, OP_LWU, OP_SLTIU, OP_SLTU, OP_BLTU, OP_BGEU,
				OP_MULHSU, OP_MULHU, OP_DIVU, OP_REMU, OP_DIVUW, OP_REMUW})
			flags_d.is_signed = 1'b0;

		if (op_d inside {OP_FENCE, OP_FENCE_I, OP_ECALL, OP_EBREAK})
		begin
			flags_d.is_special = 1'b1;
			flags_d.special_code = SPECIAL_NONE;
		end
		else if (op_d inside {OP_RDCYCLE, OP_RDCYCLEH, OP_RDTIME, OP_RDTIMEH,
				OP_RDINSTRET, OP_RDINSTRETH})
		begin
			flags_d.is_special = 1'b1;
			flags_d.special_code = SPECIAL_COUNTER;
		end
		else if (op_d == OP_JALR)
		begin
			flags_d.is_special = 1'b1;
			flags_d.special_code = SPECIAL_JUMP;
		end

		if (op_d == OP_UNKNOWN)
		begin
			fmt_d = FMT_UNKNOWN;
			flags_d = '0;
		end
	end

	assign dec.op = op_d;
	assign dec.fmt = fmt_d;
	assign dec.flags = flags_d;
	assign dec.illegal = (op_d == OP_UNKNOWN);

endmodule

`default_nettype wire

// File: hdl/operand_fields.sv
`timescale 1ns/1ps
`default_nettype none

module operand_fields #(
	parameter int IMM_WIDTH = 64
) (
	input  logic                        clk,
	input  logic                        arst_n,
	input  logic [31:0]                 instr,
	input  logic                        accept,
	decode_if.fields                    dec,
	output logic                        out_valid,
	output decode_pkg::op_e             out_op,
	output decode_pkg::fmt_e            out_fmt,
	output decode_pkg::decode_flags_t   out_flags,
	output logic                        out_illegal,
	output logic [4:0]                  rd,
	output logic [4:0]                  rs1,
	output logic [4:0]                  rs2,
	output logic [IMM_WIDTH-1:0]        imm
);
	import decode_pkg::*;

	logic signed [31:0] imm_raw;
	logic [4:0]         rd_d;
	logic [4:0]         rs1_d;
	logic [4:0]         rs2_d;

	always_comb
	begin
		case (dec.fmt)
			FMT_I: imm_raw = {{20{instr[31]}}, instr[31:20]};
			FMT_S: imm_raw = {{20{instr[31]}}, instr[31:25], instr[11:7]};
			FMT_SB: imm_raw = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
				instr[11:8], 1'b0};
			FMT_U: imm_raw = {instr[31:12], 12'h000};
			FMT_UJ: imm_raw = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
				instr[30:21], 1'b0};
			default: imm_raw = '0; // R and unknown carry no immediate
		endcase
	end

	assign rd_d = (dec.fmt inside {FMT_S, FMT_SB}) ? 5'd0 : instr[11:7];
	assign rs1_d = (dec.fmt inside {FMT_U, FMT_UJ}) ? 5'd0 : instr[19:15];
	assign rs2_d = (dec.fmt inside {FMT_R, FMT_S, FMT_SB}) ? instr[24:20] : 5'd0;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			out_valid <= 1'b0;
		else
			out_valid <= accept;
	end

	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			out_op <= dec.op;
			out_fmt <= dec.fmt;
			out_flags <= dec.flags;
			out_illegal <= dec.illegal;
			rd <= rd_d;
			rs1 <= rs1_d;
			rs2 <= rs2_d;
			imm <= IMM_WIDTH'(imm_raw); // Signed source, so this sign-extends
		end
	end

endmodule

`default_nettype wire

// File: hdl/perf_counters.sv
`timescale 1ns/1ps
`default_nettype none

module perf_counters #(
	parameter int COUNTER_WIDTH = 64
) (
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic                     accept,
	decode_if.counters               dec,
	output logic [COUNTER_WIDTH-1:0] csr_value
);
	import decode_pkg::*;

	localparam int HALF = COUNTER_WIDTH / 2;

	logic [COUNTER_WIDTH-1:0] cycle_cnt;
	logic [COUNTER_WIDTH-1:0] instret_cnt;
	logic [COUNTER_WIDTH-1:0] read_val;

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			cycle_cnt <= '0;
			instret_cnt <= '0;
		end
		else
		begin
			cycle_cnt <= cycle_cnt + 1'b1;
			if (accept && !dec.illegal)
				instret_cnt <= instret_cnt + 1'b1;
		end
	end

	// Time shares the cycle count
	always_comb
	begin
		case (dec.op)
			OP_RDCYCLE, OP_RDTIME: read_val = cycle_cnt;
			OP_RDCYCLEH, OP_RDTIMEH: read_val = COUNTER_WIDTH'(cycle_cnt[COUNTER_WIDTH-1:HALF]);
			OP_RDINSTRET: read_val = instret_cnt;
			OP_RDINSTRETH: read_val = COUNTER_WIDTH'(instret_cnt[COUNTER_WIDTH-1:HALF]);
			default: read_val = '0;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (accept)
			csr_value <= read_val; // Counts before this edge's increment
	end

endmodule

`default_nettype wire

// File: hdl/decode_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module decode_ctrl (
	input  logic            clk,
	input  logic            arst_n,
	input  logic            in_valid,
	input  logic            resume,
	input  decode_pkg::op_e op,
	output logic            accept,
	output logic            halted
);
	import decode_pkg::*;

	ctrl_state_e state;
	ctrl_state_e state_nxt;

	assign accept = in_valid && (state == ST_RUN);

	always_comb
	begin
		state_nxt = state;
		case (state)
			ST_RUN:
			begin
				// Trap instruction still decodes, later ones wait
				if (accept && (op == OP_ECALL || op == OP_EBREAK))
					state_nxt = ST_HALTED;
			end
			ST_HALTED:
			begin
				if (resume)
					state_nxt = ST_RUN;
			end
			default: state_nxt = ST_RUN;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			state <= ST_RUN;
		else
			state <= state_nxt;
	end

	assign halted = (state == ST_HALTED);

endmodule

`default_nettype wire

// File: hdl/decode_top.sv
`timescale 1ns/1ps
`default_nettype none

module decode_top #(
	parameter int COUNTER_WIDTH = 64,
	parameter int IMM_WIDTH     = 64
) (
	input  logic                      clk,
	input  logic                      arst_n,
	input  logic                      in_valid,
	input  logic [31:0]               instr,
	input  logic                      resume,
	output logic                      out_valid,
	output decode_pkg::op_e           out_op,
	output decode_pkg::fmt_e          out_fmt,
	output decode_pkg::decode_flags_t out_flags,
	output logic                      out_illegal,
	output logic [4:0]                rd,
	output logic [4:0]                rs1,
	output logic [4:0]                rs2,
	output logic [IMM_WIDTH-1:0]      imm,
	output logic [COUNTER_WIDTH-1:0]  csr_value,
	output logic                      halted
);

	logic accept;

	decode_if i_dec_if ();

	instr_decoder i_decoder (
		.instr (instr),
		.dec   (i_dec_if)
	);

	decode_ctrl i_ctrl (
		.clk      (clk),
		.arst_n   (arst_n),
		.in_valid (in_valid),
		.resume   (resume),
		.op       (i_dec_if.op),
		.accept   (accept),
		.halted   (halted)
	);

	operand_fields #(
		.IMM_WIDTH (IMM_WIDTH)
	) i_fields (
		.clk         (clk),
		.arst_n      (arst_n),
		.instr       (instr),
		.accept      (accept),
		.dec         (i_dec_if),
		.out_valid   (out_valid),
		.out_op      (out_op),
		.out_fmt     (out_fmt),
		.out_flags   (out_flags),
		.out_illegal (out_illegal),
		.rd          (rd),
		.rs1         (rs1),
		.rs2         (rs2),
		.imm         (imm)
	);

	perf_counters #(
		.COUNTER_WIDTH (COUNTER_WIDTH)
	) i_counters (
		.clk       (clk),
		.arst_n    (arst_n),
		.accept    (accept),
		.dec       (i_dec_if),
		.csr_value (csr_value)
	);

endmodule

`default_nettype wire

// File: test/decode_assert.sv
`timescale 1ns/1ps
`default_nettype none

module decode_assert #(
	parameter bit CHECK_FIELDS = 1'b0
) (
	input logic            clk,
	input logic            arst_n,
	input logic            accept,
	input logic            halted,
	input logic            out_valid,
	input logic            out_illegal,
	input decode_pkg::op_e out_op
);
	import decode_pkg::*;

	if (CHECK_FIELDS)
	begin : g_fields
		valid_after_accept: assert property (@(posedge clk) disable iff (!arst_n)
			accept |=> out_valid)
			else $error("out_valid missing one cycle after accept");

		no_valid_without_accept: assert property (@(posedge clk) disable iff (!arst_n)
			!accept |=> !out_valid)
			else $error("out_valid without an accept one cycle earlier");

		// Illegal words must carry the unknown opcode
		illegal_is_unknown: assert property (@(posedge clk) disable iff (!arst_n)
			out_valid && out_illegal |-> out_op == OP_UNKNOWN)
			else $error("out_illegal set with a known opcode");
	end
	else
	begin : g_ctrl
		no_accept_when_halted: assert property (@(posedge clk) disable iff (!arst_n)
			halted |-> !accept)
			else $error("accept while halted");
	end

endmodule

bind operand_fields decode_assert #(
	.CHECK_FIELDS (1'b1)
) i_fields_assert (
	.clk         (clk),
	.arst_n      (arst_n),
	.accept      (accept),
	.halted      (1'b0),
	.out_valid   (out_valid),
	.out_illegal (out_illegal),
	.out_op      (out_op)
);

bind decode_ctrl decode_assert #(
	.CHECK_FIELDS (1'b0)
) i_ctrl_assert (
	.clk         (clk),
	.arst_n      (arst_n),
	.accept      (accept),
	.halted      (halted),
	.out_valid   (1'b0),
	.out_illegal (1'b0),
	.out_op      (decode_pkg::OP_UNKNOWN)
);

`default_nettype wire

// File: test/tb_decode.sv
`timescale 1ns/1ps
`default_nettype none

module tb_decode;
	import decode_pkg::*;

	typedef struct {
		logic [31:0]   instr;
		logic          en;
		logic          resume;
		op_e           op;
		fmt_e          fmt;
		decode_flags_t flags;
		logic          illegal;
		logic [4:0]    rd;
		logic [4:0]    rs1;
		logic [4:0]    rs2;
		logic [63:0]   imm;
		logic          valid;
	} row_t;

	logic          clk = 1'b0;
	logic          arst_n;
	logic          in_valid;
	logic [31:0]   instr;
	logic          resume;
	logic          out_valid;
	op_e           out_op;
	fmt_e          out_fmt;
	decode_flags_t out_flags;
	logic          out_illegal;
	logic [4:0]    rd;
	logic [4:0]    rs1;
	logic [4:0]    rs2;
	logic [63:0]   imm;
	logic [63:0]   csr_value;
	logic          halted;

	row_t        rows[$];
	logic [63:0] edge_at[$];  // Cycle count seen at the accepting edge
	logic [63:0] instret_m;
	logic        halted_m;
	int          n_rows;
	int          mismatches = 0;
	int          failures = 0;
	int          cycles = 0;
	int          cycle_limit;

	decode_top i_dut (
		.clk         (clk),
		.arst_n      (arst_n),
		.in_valid    (in_valid),
		.instr       (instr),
		.resume      (resume),
		.out_valid   (out_valid),
		.out_op      (out_op),
		.out_fmt     (out_fmt),
		.out_flags   (out_flags),
		.out_illegal (out_illegal),
		.rd          (rd),
		.rs1         (rs1),
		.rs2         (rs2),
		.imm         (imm),
		.csr_value   (csr_value),
		.halted      (halted)
	);

	always #20 clk = ~clk;

	// Instruction encoders straight from the ISA field layout
	function automatic logic [31:0] r_word(int f7, int s2, int s1, int f3, int d, int opc);
		return {7'(f7), 5'(s2), 5'(s1), 3'(f3), 5'(d), 7'(opc)};
	endfunction

	function automatic logic [31:0] i_word(int imm_v, int s1, int f3, int d, int opc);
		return {12'(imm_v), 5'(s1), 3'(f3), 5'(d), 7'(opc)};
	endfunction

	function automatic logic [31:0] s_word(int imm_v, int s2, int s1, int f3);
		logic [11:0] v;
		v = 12'(imm_v);
		return {v[11:5], 5'(s2), 5'(s1), 3'(f3), v[4:0], 7'h23};
	endfunction

	function automatic logic [31:0] b_word(int imm_v, int s2, int s1, int f3);
		logic [12:0] v;
		v = 13'(imm_v);
		return {v[12], v[10:5], 5'(s2), 5'(s1), 3'(f3), v[4:1], v[11], 7'h63};
	endfunction

	function automatic logic [31:0] u_word(int imm_v, int d, int opc);
		return {20'(imm_v), 5'(d), 7'(opc)};
	endfunction

	function automatic logic [31:0] j_word(int imm_v, int d);
		logic [20:0] v;
		v = 21'(imm_v);
		return {v[20], v[10:1], v[11], v[19:12], 5'(d), 7'h6f};
	endfunction

	// Bits are load, shift, special, bracket, signed
	function automatic decode_flags_t flags_of(input logic [4:0] bits, input logic [3:0] code);
		return {bits, code};
	endfunction

	task automatic add_row(input logic [31:0] word, input op_e op, input fmt_e fmt,
		input decode_flags_t fl, input int d, input int s1, input int s2,
		input logic [63:0] imm_v);
		row_t r;
		r.instr = word;
		r.en = 1'b1;
		r.resume = 1'b0;
		r.op = op;
		r.fmt = fmt;
		r.flags = fl;
		r.illegal = (op == OP_UNKNOWN);
		r.rd = 5'(d);
		r.rs1 = 5'(s1);
		r.rs2 = 5'(s2);
		r.imm = imm_v;
		r.valid = 1'b1;
		rows.push_back(r);
	endtask

	// Row that must not come out while halted or on a resume
	task automatic add_gap(input logic [31:0] word, input logic en, input logic res);
		add_row(word, OP_UNKNOWN, FMT_UNKNOWN, '0, 0, 0, 0, '0);
		rows[rows.size() - 1].en = en;
		rows[rows.size() - 1].resume = res;
		rows[rows.size() - 1].valid = 1'b0;
	endtask

	task automatic build_table();
		decode_flags_t f_sgn;
		decode_flags_t f_uns;
		decode_flags_t f_ld;
		decode_flags_t f_ldu;
		decode_flags_t f_st;
		decode_flags_t f_sh;
		decode_flags_t f_sys;
		decode_flags_t f_cnt;
		decode_flags_t f_jmp;
		int            d;
		int            s1;
		int            s2;
		int            sel;
		f_sgn = flags_of(5'b00001, SPECIAL_NONE);
		f_uns = flags_of(5'b00000, SPECIAL_NONE);
		f_ld = flags_of(5'b10011, SPECIAL_NONE);
		f_ldu = flags_of(5'b10010, SPECIAL_NONE);
		f_st = flags_of(5'b00011, SPECIAL_NONE);
		f_sh = flags_of(5'b01001, SPECIAL_NONE);
		f_sys = flags_of(5'b00101, SPECIAL_NONE);
		f_cnt = flags_of(5'b00101, SPECIAL_COUNTER);
		f_jmp = flags_of(5'b00101, SPECIAL_JUMP);
		// One word per format
		add_row(r_word(0, 2, 1, 0, 3, 'h33), OP_ADD, FMT_R, f_sgn, 3, 1, 2, '0);
		add_row(i_word(-4, 6, 0, 5, 'h13), OP_ADDI, FMT_I, f_sgn, 5, 6, 0, 64'hffff_ffff_ffff_fffc);
		add_row(s_word(-16, 7, 8, 3), OP_SD, FMT_S, f_st, 0, 8, 7, 64'hffff_ffff_ffff_fff0);
		add_row(b_word(-8, 2, 1, 0), OP_BEQ, FMT_SB, f_sgn, 0, 1, 2, 64'hffff_ffff_ffff_fff8);
		add_row(u_word('h8a5a5, 9, 'h37), OP_LUI, FMT_U, f_sgn, 9, 0, 0, 64'hffff_ffff_8a5a_5000);
		add_row(j_word(-2048, 1), OP_JAL, FMT_UJ, f_sgn, 1, 0, 0, 64'hffff_ffff_ffff_f800);
		// Flag rules
		add_row(i_word(8, 11, 2, 10, 'h03), OP_LW, FMT_I, f_ld, 10, 11, 0, 64'd8);
		add_row(i_word(-1, 13, 3, 12, 'h03), OP_LD, FMT_I, f_ld, 12, 13, 0, '1);
		add_row(i_word(3, 15, 4, 14, 'h03), OP_LBU, FMT_I, f_ldu, 14, 15, 0, 64'd3);
		add_row(r_word(0, 18, 17, 3, 16, 'h33), OP_SLTU, FMT_R, f_uns, 16, 17, 18, '0);
		add_row(r_word(1, 21, 20, 5, 19, 'h33), OP_DIVU, FMT_R, f_uns, 19, 20, 21, '0);
		add_row(r_word(1, 24, 23, 3, 22, 'h33), OP_MULHU, FMT_R, f_uns, 22, 23, 24, '0);
		add_row(r_word('h20, 27, 26, 5, 25, 'h33), OP_SRA, FMT_R, f_sh, 25, 26, 27, '0);
		add_row(i_word('h405, 29, 5, 28, 'h1b), OP_SRAIW, FMT_I, f_sh, 28, 29, 0, 64'h405);
		add_row(i_word(16, 5, 0, 1, 'h67), OP_JALR, FMT_I, f_jmp, 1, 5, 0, 64'd16);
		add_row(i_word('h0ff, 0, 0, 0, 'h0f), OP_FENCE, FMT_I, f_sys, 0, 0, 0, 64'hff);
		add_row(32'hffff_ffff, OP_UNKNOWN, FMT_UNKNOWN, '0, 31, 31, 0, '0);
		// Counter reads as csrrs with rs1 = x0
		add_row(i_word('hc00, 0, 2, 5, 'h73), OP_RDCYCLE, FMT_I, f_cnt, 5, 0, 0,
			64'hffff_ffff_ffff_fc00);
		add_row(i_word('hc02, 0, 2, 6, 'h73), OP_RDINSTRET, FMT_I, f_cnt, 6, 0, 0,
			64'hffff_ffff_ffff_fc02);
		add_row(i_word('hc80, 0, 2, 7, 'h73), OP_RDCYCLEH, FMT_I, f_cnt, 7, 0, 0,
			64'hffff_ffff_ffff_fc80);
		add_row(i_word('hc82, 0, 2, 8, 'h73), OP_RDINSTRETH, FMT_I, f_cnt, 8, 0, 0,
			64'hffff_ffff_ffff_fc82);
		add_row(i_word('hc01, 0, 2, 9, 'h73), OP_RDTIME, FMT_I, f_cnt, 9, 0, 0,
			64'hffff_ffff_ffff_fc01);
		// Halt on ecall, blocked words, resume
		add_row(32'h0000_0073, OP_ECALL, FMT_I, f_sys, 0, 0, 0, '0);
		add_gap(r_word(0, 2, 1, 0, 3, 'h33), 1'b1, 1'b0);
		add_gap(i_word('hc02, 0, 2, 6, 'h73), 1'b1, 1'b0);
		add_gap('0, 1'b0, 1'b1);
		add_row(r_word(0, 6, 5, 0, 4, 'h33), OP_ADD, FMT_R, f_sgn, 4, 5, 6, '0);
		add_row(i_word('hc02, 0, 2, 10, 'h73), OP_RDINSTRET, FMT_I, f_cnt, 10, 0, 0,
			64'hffff_ffff_ffff_fc02);
		add_row(32'h0010_0073, OP_EBREAK, FMT_I, f_sys, 0, 0, 0, 64'd1);
		add_gap('0, 1'b0, 1'b1);
		add_row(i_word('hc00, 0, 2, 11, 'h73), OP_RDCYCLE, FMT_I, f_cnt, 11, 0, 0,
			64'hffff_ffff_ffff_fc00);
		// Back-to-back random register ALU words
		for (int k = 0; k < 12; k++)
		begin
			d = $urandom % 32;
			s1 = $urandom % 32;
			s2 = $urandom % 32;
			sel = $urandom % 5;
			case (sel)
				0: add_row(r_word(0, s2, s1, 0, d, 'h33), OP_ADD, FMT_R, f_sgn, d, s1, s2, '0);
				1: add_row(r_word('h20, s2, s1, 0, d, 'h33), OP_SUB, FMT_R, f_sgn, d, s1, s2, '0);
				2: add_row(r_word(0, s2, s1, 4, d, 'h33), OP_XOR, FMT_R, f_sgn, d, s1, s2, '0);
				3: add_row(r_word(0, s2, s1, 3, d, 'h33), OP_SLTU, FMT_R, f_uns, d, s1, s2, '0);
				4: add_row(r_word('h20, s2, s1, 5, d, 'h33), OP_SRA, FMT_R, f_sh, d, s1, s2, '0);
			endcase
		end
	endtask

	task automatic compare_value(input string name, input logic [63:0] got,
		input logic [63:0] exp, input int row);
		assert (got === exp)
		else
		begin
			mismatches++;
			$display("Mismatch %s in row %0d: expected %h, got %h", name, row, exp, got);
		end
	endtask

	task automatic check_row(input int i);
		row_t        r;
		logic [63:0] exp_csr;
		r = rows[i];
		compare_value("out_valid", 64'(out_valid), 64'(r.valid), i);
		if (r.valid)
		begin
			case (r.op)
				OP_RDCYCLE, OP_RDTIME: exp_csr = edge_at[i];
				OP_RDCYCLEH, OP_RDTIMEH: exp_csr = edge_at[i] >> 32;
				OP_RDINSTRET: exp_csr = instret_m;
				OP_RDINSTRETH: exp_csr = instret_m >> 32;
				default: exp_csr = '0;
			endcase
			compare_value("out_op", 64'(out_op), 64'(r.op), i);
			compare_value("out_fmt", 64'(out_fmt), 64'(r.fmt), i);
			compare_value("out_flags", 64'(out_flags), 64'(r.flags), i);
			compare_value("out_illegal", 64'(out_illegal), 64'(r.illegal), i);
			compare_value("rd", 64'(rd), 64'(r.rd), i);
			compare_value("rs1", 64'(rs1), 64'(r.rs1), i);
			compare_value("rs2", 64'(rs2), 64'(r.rs2), i);
			compare_value("imm", imm, r.imm, i);
			compare_value("csr_value", csr_value, exp_csr, i);
			if (!r.illegal)
				instret_m++;
		end
		if (r.valid && (r.op == OP_ECALL || r.op == OP_EBREAK))
			halted_m = 1'b1;
		else if (halted_m && r.resume)
			halted_m = 1'b0;
		compare_value("halted", 64'(halted), 64'(halted_m), i);
	endtask

	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= cycle_limit)
		begin
			failures++;
			$display("Timeout: the table did not finish within %0d cycles", cycle_limit);
			$display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	initial
	begin
		logic [63:0] edges;
		void'($urandom(32'hd7f8f77c));
		arst_n = 1'b0;
		in_valid = 1'b0;
		instr = '0;
		resume = 1'b0;
		instret_m = '0;
		halted_m = 1'b0;
		build_table();
		n_rows = rows.size();
		cycle_limit = 4 * n_rows + 50;
		repeat (4) @(posedge clk);
		arst_n <= 1'b1;
		edges = '0;
		// Drive row i, then check row i-1 which was sampled on this edge
		for (int i = 0; i <= n_rows; i++)
		begin
			@(posedge clk);
			edges++;
			if (i < n_rows)
			begin
				in_valid <= rows[i].en;
				instr <= rows[i].instr;
				resume <= rows[i].resume;
				edge_at.push_back(edges);
			end
			else
			begin
				in_valid <= 1'b0;
				resume <= 1'b0;
			end
			@(negedge clk);
			if (i > 0)
				check_row(i - 1);
		end
		$display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
		if (mismatches == 0 && failures == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// File: src.f
hdl/decode_pkg.sv
hdl/decode_if.sv
hdl/instr_decoder.sv
hdl/operand_fields.sv
hdl/perf_counters.sv
hdl/decode_ctrl.sv
hdl/decode_top.sv
test/decode_assert.sv
test/tb_decode.sv

// File: run.sh
#!/bin/sh
# Build and run, pass only if the simulation prints the pass line
verilator --binary --timing --assert -Wno-fatal --top-module tb_decode -f src.f \
	&& ./obj_dir/Vtb_decode | tee /dev/stderr | grep -q "^RESULT: PASS$" \
	|| { echo "Simulation did not pass"; exit 1; }
